// ==== hdl/vu_params.svh ====
`ifndef VU_PARAMS_SVH
`define VU_PARAMS_SVH

// Pixel and packed word widths.
`define VU_PIXEL_BIT	32
`define VU_PACK_BIT		64

// Coordinates, line memory and sync ring addresses.
`define VU_COORD_W		10

// Pixels carried by one packed word.
`define VU_PACK_DIV		(`VU_PACK_BIT / `VU_PIXEL_BIT)

`endif

// ==== hdl/vu_pkg.sv ====
`include "vu_params.svh"

package vu_pkg;

// One unpacked pixel.
typedef logic [`VU_PIXEL_BIT-1:0]	pixel_t;

// Pixel column, word column or line number.
typedef logic [`VU_COORD_W-1:0]		coord_t;

// Packed word as written by the source.
// Element 0 of pix is the least significant pixel.
typedef union packed
{
	logic [`VU_PACK_BIT-1:0]	raw;
	pixel_t [`VU_PACK_DIV-1:0]	pix;
} pack_word_u;

endpackage

// ==== hdl/pixel_stream_if.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

interface pixel_stream_if
	import vu_pkg::*;
();

// One beat per cycle with valid high, no stall.
logic	valid;
coord_t	x;
pixel_t	data;
logic	last;

modport src
(
	output	valid,
	output	x,
	output	data,
	output	last
);

modport dst
(
	input	valid,
	input	x,
	input	data,
	input	last
);

endinterface

// ==== hdl/line_store_unpack.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

module line_store_unpack
	import vu_pkg::*;
(
	input	logic			in_pclk,
	input	logic			in_rstn,

	input	coord_t			i_x,
	input	logic			i_wr_valid,
	input	logic			i_de,
	input	pack_word_u		i_data,

	pixel_stream_if.src		o_pix
);

localparam int DIV		= `VU_PACK_DIV;
localparam int SUB_W	= (DIV > 1) ? $clog2(DIV) : 1;
localparam int ADDR_W	= `VU_COORD_W + 1;

// Two banks, bank select is the top address bit.
logic [`VU_PACK_BIT-1:0]	line_mem [0:(1 << ADDR_W)-1];

logic				r_de_d;
logic				r_wr_bank;
logic				r_has_wr;
coord_t				r_max_col;
logic				r_pend;
logic				r_pend_bank;
coord_t				r_pend_col;
logic				r_go;

logic				a_busy;
logic				a_bank;
coord_t				a_col;
coord_t				a_last_col;
logic [SUB_W-1:0]	a_sub;
logic				b_vld;
logic				b_last;
coord_t				b_col;
logic [SUB_W-1:0]	b_sub;
logic [`VU_PACK_BIT-1:0]	b_q;
pack_word_u			r_word;
logic [SUB_W-1:0]	c_sub;

logic				de_rise;
logic				de_fall;
logic				wr_acc;
logic				a_word_end;
logic				a_line_end;

assign de_rise		= i_de & ~r_de_d;
assign de_fall		= ~i_de & r_de_d;
assign wr_acc		= i_wr_valid & i_de;
assign a_word_end	= (a_sub == SUB_W'(DIV - 1));
assign a_line_end	= a_word_end && (a_col == a_last_col);

//////////////////////////////////////////////////
// Write side and line capture.
//////////////////////////////////////////////////
always_ff @(posedge in_pclk)
begin
	if (!in_rstn)
	begin
		r_de_d		<= 1'b0;
		r_wr_bank	<= 1'b0;
		r_has_wr	<= 1'b0;
		r_max_col	<= '0;
		r_pend		<= 1'b0;
		r_pend_bank	<= 1'b0;
		r_pend_col	<= '0;
		r_go		<= 1'b0;
	end
	else
	begin
		r_de_d	<= i_de;
		// Readout of the stored line starts with the next line.
		r_go	<= de_rise & r_pend;

		if (wr_acc)
		begin
			r_has_wr <= 1'b1;
			if (!r_has_wr || (i_x > r_max_col))
				r_max_col <= i_x;
		end

		if (r_go)
			r_pend <= 1'b0;

		if (de_fall)
		begin
			r_has_wr <= 1'b0;
			if (r_has_wr)
			begin
				r_pend		<= 1'b1;
				r_pend_bank	<= r_wr_bank;
				r_pend_col	<= r_max_col;
				r_wr_bank	<= ~r_wr_bank;
			end
		end
	end
end

//////////////////////////////////////////////////
// Read side, one pixel per clock.
//////////////////////////////////////////////////
always_ff @(posedge in_pclk)
begin
	if (!in_rstn)
	begin
		a_busy		<= 1'b0;
		a_bank		<= 1'b0;
		a_col		<= '0;
		a_last_col	<= '0;
		a_sub		<= '0;
		b_vld		<= 1'b0;
		b_last		<= 1'b0;
		o_pix.valid	<= 1'b0;
		o_pix.last	<= 1'b0;
	end
	else
	begin
		if (r_go)
		begin
			a_busy		<= 1'b1;
			a_bank		<= r_pend_bank;
			a_last_col	<= r_pend_col;
			a_col		<= '0;
			a_sub		<= '0;
		end
		else if (a_busy)
		begin
			if (a_word_end)
			begin
				a_sub	<= '0;
				a_col	<= a_col + 1'b1;
				if (a_col == a_last_col)
					a_busy <= 1'b0;
			end
			else
				a_sub	<= a_sub + 1'b1;
		end

		b_vld		<= a_busy;
		b_last		<= a_busy & a_line_end;
		o_pix.valid	<= b_vld;
		o_pix.last	<= b_last;
	end
end

always_ff @(posedge in_pclk)
begin
	if (wr_acc)
		line_mem[{r_wr_bank, i_x}] <= i_data.raw;
	b_q			<= line_mem[{a_bank, a_col}];
	b_col		<= a_col;
	b_sub		<= a_sub;
	r_word.raw	<= b_q;
	c_sub		<= b_sub;
	o_pix.x		<= coord_t'(int'(b_col) * DIV + int'(b_sub));
end

assign o_pix.data = r_word.pix[c_sub];

// The source may never write into the line being played back.
assert property (@(posedge in_pclk) disable iff (!in_rstn)
	(wr_acc && a_busy) |-> (r_wr_bank != a_bank))
	else $error("line_store_unpack: write into bank under readout");

// A new line must not start before the previous readout is done.
assert property (@(posedge in_pclk) disable iff (!in_rstn)
	de_rise |-> (!a_busy && !r_go))
	else $error("line_store_unpack: line period too short for readout");

endmodule

// ==== hdl/line_sync_delay.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

module line_sync_delay
	import vu_pkg::*;
(
	input	logic	in_pclk,
	input	logic	in_rstn,

	input	logic	i_de,
	input	logic	i_hs,
	input	logic	i_vs,

	output	logic	o_hs,
	output	logic	o_vs,
	output	logic	o_line_tick
);

localparam int DEPTH = 1 << `VU_COORD_W;

// Entry layout is {de, vs, hs}.
logic [2:0]					sync_ring [0:DEPTH-1];

logic [`VU_COORD_W-1:0]		r_wr_ptr;
logic [`VU_COORD_W-1:0]		r_cnt;
logic [`VU_COORD_W-1:0]		r_period;
logic [`VU_COORD_W-1:0]		rd_ptr;
logic						r_de_d;
logic						r_seen;
logic						r_period_vld;
logic						r_dly_de_d;
logic						de_rise;
logic [2:0]					rd_word;
logic						dly_de;

assign de_rise = i_de & ~r_de_d;

//////////////////////////////////////////////////
// Line period measurement.
//////////////////////////////////////////////////
always_ff @(posedge in_pclk)
begin
	if (!in_rstn)
	begin
		r_de_d			<= 1'b0;
		r_cnt			<= '0;
		r_period		<= '0;
		r_seen			<= 1'b0;
		r_period_vld	<= 1'b0;
		r_wr_ptr		<= '0;
		r_dly_de_d		<= 1'b0;
	end
	else
	begin
		r_de_d		<= i_de;
		r_wr_ptr	<= r_wr_ptr + 1'b1;
		r_dly_de_d	<= dly_de;

		// Saturates so the ring check below still fires.
		if (de_rise)
			r_cnt <= `VU_COORD_W'(1);
		else if (r_cnt != '1)
			r_cnt <= r_cnt + 1'b1;

		if (de_rise)
		begin
			r_seen <= 1'b1;
			if (r_seen)
			begin
				r_period		<= r_cnt;
				r_period_vld	<= 1'b1;
			end
		end
	end
end

//////////////////////////////////////////////////
// Sync ring, written every cycle.
//////////////////////////////////////////////////
always_ff @(posedge in_pclk)
	sync_ring[r_wr_ptr] <= {i_de, i_vs, i_hs};

// Same offset as the pixel path.
assign rd_ptr	= r_wr_ptr - r_period - `VU_COORD_W'(4);
assign rd_word	= sync_ring[rd_ptr];

assign dly_de		= r_period_vld & rd_word[2];
assign o_vs			= r_period_vld & rd_word[1];
assign o_hs			= r_period_vld & rd_word[0];
assign o_line_tick	= dly_de & ~r_dly_de_d;

assert property (@(posedge in_pclk) disable iff (!in_rstn)
	(de_rise && r_seen) |-> (int'(r_cnt) + 4 < DEPTH))
	else $error("line_sync_delay: line period exceeds sync ring");

endmodule

// ==== hdl/output_aligner.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

module output_aligner
	import vu_pkg::*;
(
	input	logic			in_pclk,
	input	logic			in_rstn,

	pixel_stream_if.dst		i_pix,
	input	logic			i_hs,
	input	logic			i_vs,
	input	logic			i_line_tick,

	output	coord_t			o_x,
	output	coord_t			o_y,
	output	logic			o_valid,
	output	logic			o_de,
	output	logic			o_hs,
	output	logic			o_vs,
	output	pixel_t			o_data
);

// Line number of the beats now on the interface.
coord_t		r_y;

always_ff @(posedge in_pclk)
begin
	if (!in_rstn)
	begin
		o_valid	<= 1'b0;
		o_de	<= 1'b0;
		o_hs	<= 1'b0;
		o_vs	<= 1'b0;
		o_y		<= '0;
		r_y		<= '0;
	end
	else
	begin
		o_valid	<= i_pix.valid;
		o_de	<= i_pix.valid;
		o_hs	<= i_hs;
		o_vs	<= i_vs;
		o_y		<= r_y;

		// Frame restarts at line 0 once vs drops.
		if (!i_vs)
			r_y <= '0;
		else if (i_pix.valid && i_pix.last)
			r_y <= r_y + 1'b1;
	end
end

always_ff @(posedge in_pclk)
begin
	o_x		<= i_pix.x;
	o_data	<= i_pix.data;
end

// Replayed line start must meet the first pixel of that line.
assert property (@(posedge in_pclk) disable iff (!in_rstn)
	i_line_tick |-> (i_pix.valid && (i_pix.x == '0)))
	else $error("output_aligner: delayed sync out of step with pixels");

endmodule

// ==== hdl/video_unpack_top.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

module video_unpack_top
	import vu_pkg::*;
(
	input	logic						in_pclk,
	input	logic						in_rstn,

	input	coord_t						i_x,
	input	logic						i_wr_valid,
	input	logic						i_de,
	input	logic						i_hs,
	input	logic						i_vs,
	input	logic [`VU_PACK_BIT-1:0]	i_data,

	output	coord_t						o_x,
	output	coord_t						o_y,
	output	logic						o_valid,
	output	logic						o_de,
	output	logic						o_hs,
	output	logic						o_vs,
	output	pixel_t						o_data
);

logic	dly_hs;
logic	dly_vs;
logic	line_tick;

pixel_stream_if pix_if ();

// Pixel data path.
line_store_unpack u_line_store_unpack
(
	.in_pclk	(in_pclk),
	.in_rstn	(in_rstn),
	.i_x		(i_x),
	.i_wr_valid	(i_wr_valid),
	.i_de		(i_de),
	.i_data		(i_data),
	.o_pix		(pix_if)
);

// Timing path, one line behind.
line_sync_delay u_line_sync_delay
(
	.in_pclk		(in_pclk),
	.in_rstn		(in_rstn),
	.i_de			(i_de),
	.i_hs			(i_hs),
	.i_vs			(i_vs),
	.o_hs			(dly_hs),
	.o_vs			(dly_vs),
	.o_line_tick	(line_tick)
);

output_aligner u_output_aligner
(
	.in_pclk		(in_pclk),
	.in_rstn		(in_rstn),
	.i_pix			(pix_if),
	.i_hs			(dly_hs),
	.i_vs			(dly_vs),
	.i_line_tick	(line_tick),
	.o_x			(o_x),
	.o_y			(o_y),
	.o_valid		(o_valid),
	.o_de			(o_de),
	.o_hs			(o_hs),
	.o_vs			(o_vs),
	.o_data			(o_data)
);

endmodule

// ==== dv/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare one pixel word.
task automatic check_pixel(input pixel_t act, input pixel_t exp, input string what);
begin
	if (act !== exp)
		report_failure($sformatf("Fail @ %0t: %s is %h, expected %h", $time, what, act, exp));
end
endtask

// Compare one coordinate.
task automatic check_coord(input coord_t act, input coord_t exp, input string what);
begin
	if (act !== exp)
		report_failure($sformatf("Fail @ %0t: %s is %0d, expected %0d", $time, what, act, exp));
end
endtask

// Compare a pair of timing bits.
task automatic check_sync(input logic [1:0] act, input logic [1:0] exp, input string what);
begin
	if (act !== exp)
		report_failure($sformatf("Fail @ %0t: %s is %b, expected %b", $time, what, act, exp));
end
endtask

`endif

// ==== dv/tb_video_unpack.sv ====
`timescale 1ns/100ps
`include "vu_params.svh"

module tb_video_unpack
	import vu_pkg::*;
();

localparam int DIV			= `VU_PACK_DIV;
localparam int PIX_W		= `VU_PIXEL_BIT;
localparam int LINE_P		= 48;
localparam int DE_START		= 6;
localparam int DE_END		= 26;
localparam int SYNC_LAT		= LINE_P + 5;

logic						in_pclk;
logic						in_rstn;
coord_t						i_x;
logic						i_wr_valid;
logic						i_de;
logic						i_hs;
logic						i_vs;
logic [`VU_PACK_BIT-1:0]	i_data;
coord_t						o_x;
coord_t						o_y;
logic						o_valid;
logic						o_de;
logic						o_hs;
logic						o_vs;
pixel_t						o_data;

// Parsed stimulus and expected pixel stream.
int							ln_words[$];
int							ln_gap[$];
bit							ln_first[$];
logic [`VU_PACK_BIT-1:0]	word_q[$];
pixel_t						exp_pix[$];
coord_t						exp_x[$];
coord_t						exp_y[$];

logic [1:0]					sync_hist[int];
bit							vld_win[int];
logic						exp_vld;
bit							mon_on;
int							cyc;
int							de_rises;
int							rise2;
logic						prev_de;
int							wd_limit;

video_unpack_top video_unpack_top_i
(
	.in_pclk	(in_pclk),
	.in_rstn	(in_rstn),
	.i_x		(i_x),
	.i_wr_valid	(i_wr_valid),
	.i_de		(i_de),
	.i_hs		(i_hs),
	.i_vs		(i_vs),
	.i_data		(i_data),
	.o_x		(o_x),
	.o_y		(o_y),
	.o_valid	(o_valid),
	.o_de		(o_de),
	.o_hs		(o_hs),
	.o_vs		(o_vs),
	.o_data		(o_data)
);

task automatic report_failure(input string msg);
begin
	$display("%s", msg);
	$display("TESTBENCH FAILED");
	$fatal(1);
end
endtask

`include "tb_checks.svh"

initial
	in_pclk = 1'b0;

always
	#5 in_pclk = ~in_pclk;

//////////////////////////////////////////////////
// Stimulus file.
//////////////////////////////////////////////////
// Next line that is neither blank nor a comment.
task automatic next_record(input int fd, output string s);
begin
	s = "";
	while ((s.len() == 0) || (s.getc(0) == "#") || (s.getc(0) == "\n"))
	begin
		if ($fgets(s, fd) == 0)
			report_failure("Stimulus file ends before all lines were read.");
	end
end
endtask

task automatic read_stimulus();
	int							fd;
	int							nframes;
	int							nlines;
	int							w;
	int							g;
	string						s;
	logic [`VU_PACK_BIT-1:0]	word;
begin
	fd = $fopen("dv/unpack_stimulus.txt", "r");
	if (fd == 0)
		report_failure("Cannot open dv/unpack_stimulus.txt.");
	next_record(fd, s);
	if ($sscanf(s, "%d", nframes) != 1)
		report_failure("Bad frame count in stimulus file.");
	for (int f = 0; f < nframes; f++)
	begin
		next_record(fd, s);
		if ($sscanf(s, "%d", nlines) != 1)
			report_failure("Bad line count in stimulus file.");
		for (int l = 0; l < nlines; l++)
		begin
			next_record(fd, s);
			if ($sscanf(s, "%d %d", w, g) != 2)
				report_failure("Bad line record in stimulus file.");
			ln_words.push_back(w);
			ln_gap.push_back(g);
			ln_first.push_back(l == 0);
			for (int k = 0; k < w; k++)
			begin
				next_record(fd, s);
				if ($sscanf(s, "%h", word) != 1)
					report_failure("Bad packed word in stimulus file.");
				word_q.push_back(word);
				// Lowest pixel of the word leaves first.
				for (int j = 0; j < DIV; j++)
				begin
					exp_pix.push_back(word[j*PIX_W +: PIX_W]);
					exp_x.push_back(coord_t'(k * DIV + j));
					exp_y.push_back(coord_t'(l));
				end
			end
		end
	end
	$fclose(fd);
end
endtask

//////////////////////////////////////////////////
// One input line of LINE_P cycles.
//////////////////////////////////////////////////
task automatic drive_line(input int words, input int gap, input bit first, input int base);
	int	slot[$];
	int	t;
	int	rem;
	int	k;
begin
	t = DE_START;
	for (int n = 0; n < words; n++)
	begin
		slot.push_back(t);
		t = t + 1 + gap;
		rem = words - 1 - n;
		// Jitter only where the rest of the line still fits in de.
		if ((rem > 0) && (t + 1 + (rem - 1) * (1 + gap) < DE_END))
			t = t + int'($urandom % 2);
	end
	if ((words > 0) && (slot[words-1] >= DE_END))
		report_failure("Line in stimulus file does not fit in the de window.");
	k = 0;
	for (int off = 0; off < LINE_P; off++)
	begin
		@(posedge in_pclk);
		i_hs	<= (off < 4);
		i_vs	<= !(first && (off < 4));
		i_de	<= (off >= DE_START) && (off < DE_END);
		if ((k < words) && (slot[k] == off))
		begin
			i_wr_valid	<= 1'b1;
			i_x			<= coord_t'(k);
			i_data		<= word_q[base+k];
			k++;
		end
		else
			i_wr_valid	<= 1'b0;
	end
end
endtask

//////////////////////////////////////////////////
// Output monitor, sampled mid-cycle.
//////////////////////////////////////////////////
always @(negedge in_pclk)
begin
	if (mon_on)
	begin
		sync_hist[cyc] = {i_vs, i_hs};
		if (i_de && !prev_de)
		begin
			de_rises++;
			if (de_rises == 2)
				rise2 = cyc;
			// Pixels of this line leave one line later, back to back.
			if (de_rises <= ln_words.size())
			begin
				for (int n = 0; n < ln_words[de_rises-1] * DIV; n++)
					vld_win[cyc + SYNC_LAT + n] = 1'b1;
			end
		end
		prev_de = i_de;

		exp_vld = vld_win.exists(cyc) ? 1'b1 : 1'b0;
		check_sync({o_valid, o_de}, {exp_vld, exp_vld}, "valid and de");
		if (de_rises < 2)
			check_sync({o_vs, o_hs}, 2'b00, "vs and hs during first line");
		else if (cyc >= rise2 + 2)
			check_sync({o_vs, o_hs}, sync_hist[cyc-SYNC_LAT], "delayed vs and hs");
		if (o_valid)
		begin
			if (exp_pix.size() == 0)
				report_failure("DUT sent a pixel beyond the expected stream.");
			check_pixel(o_data, exp_pix.pop_front(), "pixel data");
			check_coord(o_x, exp_x.pop_front(), "pixel x");
			check_coord(o_y, exp_y.pop_front(), "line y");
		end
		cyc++;
	end
end

// Watchdog.
initial
begin
	wait (wd_limit > 0);
	repeat (wd_limit) @(posedge in_pclk);
	report_failure("Watchdog expired before the pixel stream completed.");
end

initial
begin
	int	base;

	void'($urandom(23674));
	in_rstn		= 1'b0;
	i_x			= '0;
	i_wr_valid	= 1'b0;
	i_de		= 1'b0;
	i_hs		= 1'b0;
	i_vs		= 1'b0;
	i_data		= '0;
	mon_on		= 1'b0;
	cyc			= 0;
	de_rises	= 0;
	rise2		= 0;
	prev_de		= 1'b0;
	wd_limit	= 0;

	read_stimulus();
	wd_limit = 10 + (ln_words.size() + 1) * LINE_P + 1000;

	repeat (10) @(posedge in_pclk);
	in_rstn	<= 1'b1;
	mon_on	<= 1'b1;

	base = 0;
	for (int l = 0; l < ln_words.size(); l++)
	begin
		drive_line(ln_words[l], ln_gap[l], ln_first[l], base);
		base = base + ln_words[l];
	end
	// An empty line starts readout of the last stored line.
	drive_line(0, 0, 1'b0, base);
	@(posedge in_pclk);
	i_de		<= 1'b0;
	i_wr_valid	<= 1'b0;
	repeat (3) @(posedge in_pclk);

	if (exp_pix.size() != 0)
		report_failure($sformatf("DUT left %0d expected pixels unsent.", exp_pix.size()));
	else
	begin
		$display("TESTBENCH PASSED");
		$finish;
	end
end

endmodule

// ==== compile.f ====
+incdir+hdl
+incdir+dv
hdl/vu_pkg.sv
hdl/pixel_stream_if.sv
hdl/line_store_unpack.sv
hdl/line_sync_delay.sv
hdl/output_aligner.sv
hdl/video_unpack_top.sv
dv/tb_video_unpack.sv

// ==== Makefile ====
# Verilator flow for the video unpacker.
# Any variable below can be overridden on the command line.

VERILATOR	?= verilator
TOP		?= tb_video_unpack
DUT_TOP		?= video_unpack_top
FILELIST	?= compile.f
BUILD_DIR	?= obj_dir
LOG		?= sim.log
PASS_STR	?= TESTBENCH PASSED
VFLAGS		?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+hdl hdl/vu_pkg.sv \
		hdl/pixel_stream_if.sv hdl/line_store_unpack.sv hdl/line_sync_delay.sv \
		hdl/output_aligner.sv hdl/video_unpack_top.sv --top-module $(DUT_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(PASS_STR)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/unpack_stimulus.txt ====
# Frame count, then per frame its line count.
# Per line: word count and idle cycles after each write, then one hex packed word per row.
2
3
4 0
0000000100000000
0000000300000002
0000000500000004
0000000700000006
2 2
a1b2c3d4e5f60718
1122334455667788
3 1
deadbeefcafef00d
0f0e0d0c0b0a0908
8000000100000001
2
1 3
76543210fedcba98
2 0
5a5a5a5aa5a5a5a5
ffffffff00000000
